// ==== Makefile ====
# Verilator flow for the polynomial actor

VERILATOR  ?= verilator
FILELIST   ?= files.f
TB_TOP     ?= tb_poly_actor
RTL_TOP    ?= poly_actor
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q -F '$(PASS_TEXT)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
hdl/poly_pkg.sv
hdl/token_fifo.sv
hdl/command_decoder.sv
hdl/coef_setup.sv
hdl/poly_eval.sv
hdl/firing_ctrl.sv
hdl/poly_actor.sv
testbench/tb_poly_actor.sv

// ==== hdl/coef_setup.sv ====
// Setup engine that loads a slot's coefficients from data tokens and keeps the slot tables
`timescale 1ns/1ps
module coef_setup import poly_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic              clear,
    input  logic [2:0]        slot,
    input  logic [4:0]        degree,
    tok_rd_if.reader          data,
    output logic              done,
    input  logic [2:0]        rd_slot,
    input  logic [3:0]        rd_index,
    output logic [word_w-1:0] coef,
    output logic [4:0]        slot_degree,
    output logic              slot_valid
);
    logic [word_w-1:0]     mem [coef_words];
    logic [4:0]            degree_tab [slot_count];
    logic [slot_count-1:0] valid;
    logic                  busy;
    logic [3:0]            idx;
    logic [2:0]            slot_r;
    logic [4:0]            degree_r;
    logic                  last_pop;

    function automatic logic [addr_w-1:0] coef_addr(input logic [2:0] s, input logic [3:0] i);
        return addr_w'(s) * addr_w'(max_degree + 1) + addr_w'(i);
    endfunction

    assign data.pop = busy && !data.empty;
    assign last_pop = data.pop && ({1'b0, idx} == degree_r);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            busy <= 1'b0;
            done <= 1'b0;
            idx <= '0;
            valid <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (clear)
                valid <= '0;                        // RST command drops every slot
            if (start)
            begin
                busy <= 1'b1;
                idx <= '0;
            end
            else if (data.pop)
            begin
                idx <= idx + 1'b1;
                if (last_pop)
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    valid[slot_r] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            slot_r <= slot;
            degree_r <= degree;
        end
        if (data.pop)
            mem[coef_addr(slot_r, idx)] <= data.token;  // Index 0 holds the highest order
        if (last_pop)
            degree_tab[slot_r] <= degree_r;
    end

    assign coef = mem[coef_addr(rd_slot, rd_index)];
    assign slot_degree = degree_tab[rd_slot];
    assign slot_valid = valid[rd_slot];
endmodule

// ==== hdl/command_decoder.sv ====
// Command fetch engine that pops one command word and presents its decoded fields
`timescale 1ns/1ps
module command_decoder import poly_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    tok_rd_if.reader   cmd,
    output logic       cmd_ready,
    output logic       done,
    output logic [7:0] opcode,
    output logic [2:0] slot,
    output logic [4:0] arg
);
    cmd_word_u word;

    assign cmd_ready = (cmd.count >= cnt_w'(1));    // Firing rule for a fetch
    assign cmd.pop = start && !cmd.empty;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            done <= 1'b0;
        else
            done <= start;                          // Word is latched when done rises
    end

    always_ff @(posedge clk)
    begin
        if (cmd.pop)
            word <= cmd.token;
    end

    assign opcode = word.stp_view.opcode;
    assign slot = word.stp_view.slot;

    // The same low bits are the STP degree and the EVB block count
    assign arg = word.stp_view.degree;
endmodule

// ==== hdl/firing_ctrl.sv ====
// Firing controller that fetches commands, starts the matching engine and drives the output
`timescale 1ns/1ps
module firing_ctrl import poly_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_ready,
    output logic        fetch_start,
    input  logic        fetch_done,
    input  logic [7:0]  opcode,
    input  logic [2:0]  slot,
    input  logic [4:0]  arg,
    output logic        stp_start,
    input  logic        stp_done,
    output logic        eval_start,
    output logic        eval_block,
    input  logic        eval_done,
    output logic        clear_slots,
    tok_rd_if.reader    data_fifo,
    tok_rd_if.owner     stp_data,
    tok_rd_if.owner     eval_data,
    input  logic        eval_out_valid,
    input  logic [31:0] eval_result,
    input  logic [31:0] eval_status,
    output logic        result_valid,
    output logic [31:0] result,
    output logic [31:0] status
);
    logic [3:0] state;
    logic [3:0] next_state;
    logic       stp_mode;
    logic       eval_mode;
    logic       eval_out;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= fc_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            fc_idle:
                if (cmd_ready)
                    next_state = fc_fetch_start;
            fc_fetch_start:
                next_state = fc_fetch_wait;
            fc_fetch_wait:
                if (fetch_done)
                    next_state = fc_decode;
            fc_decode:
            begin
                case (opcode)
                    op_stp:
                        if (arg > 5'(max_degree))
                            next_state = fc_err_out;
                        else if (data_fifo.count > cnt_w'(arg))   // Needs degree+1 tokens
                            next_state = fc_stp_start;
                    op_evp, op_evb:
                        if (!data_fifo.empty)
                            next_state = fc_eval_start;
                    op_rst:
                        next_state = fc_clear;
                    default:
                        next_state = fc_err_out;
                endcase
            end
            fc_stp_start:
                next_state = fc_stp_wait;
            fc_stp_wait:
                if (stp_done)
                    next_state = fc_idle;
            fc_eval_start:
                next_state = fc_eval_wait;
            fc_eval_wait:
                if (eval_done)
                    next_state = fc_idle;
            default:
                next_state = fc_idle;                       // Clear and error output take one cycle
        endcase
    end

    assign fetch_start = (state == fc_fetch_start);
    assign stp_start = (state == fc_stp_start);
    assign eval_start = (state == fc_eval_start);
    assign eval_block = (opcode == op_evb);
    assign clear_slots = (state == fc_clear);

    // Data stream goes to whichever engine owns the current firing
    assign stp_mode = (state == fc_stp_start) || (state == fc_stp_wait);
    assign eval_mode = (state == fc_eval_start) || (state == fc_eval_wait);
    assign stp_data.token = data_fifo.token;
    assign stp_data.count = data_fifo.count;
    assign stp_data.empty = data_fifo.empty;
    assign eval_data.token = data_fifo.token;
    assign eval_data.count = data_fifo.count;
    assign eval_data.empty = data_fifo.empty;
    assign data_fifo.pop = stp_mode ? stp_data.pop : (eval_mode && eval_data.pop);

    assign eval_out = (state == fc_eval_wait) && eval_out_valid;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            result_valid <= 1'b0;
        else
            result_valid <= eval_out || (state == fc_err_out);
    end

    always_ff @(posedge clk)
    begin
        if (state == fc_err_out)
        begin
            result <= '0;
            status <= make_status(opcode, slot, arg, 1'b1, '0);
        end
        else if (eval_out)
        begin
            result <= eval_result;
            status <= eval_status;
        end
    end

    // A pop from an engine outside its own firing would be lost in the routing
    assert property (@(posedge clk) disable iff (!rst)
        (!stp_data.pop || stp_mode) && (!eval_data.pop || eval_mode))
        else $error("firing_ctrl: data pop from an engine that is not firing");
endmodule

// ==== hdl/poly_actor.sv ====
// Polynomial evaluation actor with command and data token FIFOs and its firing engines
`timescale 1ns/1ps
module poly_actor import poly_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              data_push,
    input  logic [word_w-1:0] data_token,
    input  logic              cmd_push,
    input  logic [word_w-1:0] cmd_token,
    output logic              data_full,
    output logic              cmd_full,
    output logic              result_valid,
    output logic [31:0]       result,
    output logic [31:0]       status
);
    tok_rd_if cmd_rd ();
    tok_rd_if data_rd ();
    tok_rd_if stp_rd ();
    tok_rd_if eval_rd ();

    logic              cmd_ready;
    logic              fetch_start;
    logic              fetch_done;
    logic [7:0]        opcode;
    logic [2:0]        slot;
    logic [4:0]        arg;
    logic              stp_start;
    logic              stp_done;
    logic              eval_start;
    logic              eval_block;
    logic              eval_done;
    logic              clear_slots;
    logic [2:0]        rd_slot;
    logic [3:0]        rd_index;
    logic [word_w-1:0] coef;
    logic [4:0]        slot_degree;
    logic              slot_valid;
    logic              eval_out_valid;
    logic [31:0]       eval_result;
    logic [31:0]       eval_status;

    token_fifo u_cmd_fifo (.clk(clk), .rst(rst), .push(cmd_push), .token_in(cmd_token),
                           .full(cmd_full), .rd(cmd_rd));

    token_fifo u_data_fifo (.clk(clk), .rst(rst), .push(data_push), .token_in(data_token),
                            .full(data_full), .rd(data_rd));

    command_decoder u_decoder (.clk(clk), .rst(rst), .start(fetch_start), .cmd(cmd_rd),
                               .cmd_ready(cmd_ready), .done(fetch_done), .opcode(opcode),
                               .slot(slot), .arg(arg));

    coef_setup u_setup (.clk(clk), .rst(rst), .start(stp_start), .clear(clear_slots),
                        .slot(slot), .degree(arg), .data(stp_rd), .done(stp_done),
                        .rd_slot(rd_slot), .rd_index(rd_index), .coef(coef),
                        .slot_degree(slot_degree), .slot_valid(slot_valid));

    poly_eval u_eval (.clk(clk), .rst(rst), .start(eval_start), .slot(slot), .count(arg),
                      .block(eval_block), .data(eval_rd), .rd_slot(rd_slot),
                      .rd_index(rd_index), .coef(coef), .slot_degree(slot_degree),
                      .slot_valid(slot_valid), .done(eval_done), .out_valid(eval_out_valid),
                      .result(eval_result), .status(eval_status));

    firing_ctrl u_ctrl (.clk(clk), .rst(rst), .cmd_ready(cmd_ready), .fetch_start(fetch_start),
                        .fetch_done(fetch_done), .opcode(opcode), .slot(slot), .arg(arg),
                        .stp_start(stp_start), .stp_done(stp_done), .eval_start(eval_start),
                        .eval_block(eval_block), .eval_done(eval_done),
                        .clear_slots(clear_slots), .data_fifo(data_rd), .stp_data(stp_rd),
                        .eval_data(eval_rd), .eval_out_valid(eval_out_valid),
                        .eval_result(eval_result), .eval_status(eval_status),
                        .result_valid(result_valid), .result(result), .status(status));
endmodule

// ==== hdl/poly_eval.sv ====
// Evaluation engine that runs Horner's rule on a stored slot for one x or a block of x values
`timescale 1ns/1ps
module poly_eval import poly_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [2:0]        slot,
    input  logic [4:0]        count,
    input  logic              block,
    tok_rd_if.reader          data,
    output logic [2:0]        rd_slot,
    output logic [3:0]        rd_index,
    input  logic [word_w-1:0] coef,
    input  logic [4:0]        slot_degree,
    input  logic              slot_valid,
    output logic              done,
    output logic              out_valid,
    output logic [31:0]       result,
    output logic [31:0]       status
);
    logic [1:0]               state;
    logic [3:0]               idx;
    logic [4:0]               left;
    logic [4:0]               x_index;
    logic [2:0]               slot_r;
    logic                     block_r;
    logic signed [word_w-1:0] x_r;
    logic signed [31:0]       acc;
    logic signed [31:0]       acc_next;
    logic                     last_coef;

    assign rd_slot = (state == pe_idle) ? slot : slot_r;   // Validity is checked on start
    assign rd_index = idx;
    assign data.pop = (state == pe_wait_x) && !data.empty;

    assign acc_next = acc * x_r + $signed(coef);          // Wraps modulo 2^32
    assign last_coef = (state == pe_run) && ({1'b0, idx} == slot_degree);

    assign out_valid = last_coef || (state == pe_err);
    assign done = (state == pe_err) || (last_coef && (left == 5'd1));
    assign result = (state == pe_err) ? '0 : acc_next;
    assign status = make_status(block_r ? op_evb : op_evp, slot_r, slot_degree,
                                state == pe_err, 15'(x_index));

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= pe_idle;
            idx <= '0;
            left <= '0;
            x_index <= '0;
        end
        else
        begin
            case (state)
                pe_idle:
                begin
                    if (start)
                    begin
                        state <= slot_valid ? pe_wait_x : pe_err;
                        left <= (block && (count != '0)) ? count : 5'd1;
                        x_index <= '0;
                    end
                end
                pe_wait_x:
                begin
                    if (data.pop)
                    begin
                        state <= pe_run;
                        idx <= '0;
                    end
                end
                pe_run:
                begin
                    idx <= idx + 1'b1;
                    if (last_coef)
                    begin
                        left <= left - 1'b1;
                        x_index <= x_index + 1'b1;
                        state <= (left == 5'd1) ? pe_idle : pe_wait_x;
                    end
                end
                default:
                    state <= pe_idle;                     // Error output lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == pe_idle && start)
        begin
            slot_r <= slot;
            block_r <= block;
        end
        if (data.pop)
        begin
            x_r <= data.token;
            acc <= '0;
        end
        else if (state == pe_run)
            acc <= acc_next;
    end

    // The degree table in coef_setup bounds every coefficient read
    assert property (@(posedge clk) disable iff (!rst)
        (state == pe_run) |-> ({1'b0, idx} <= slot_degree))
        else $error("poly_eval: coefficient index past slot degree");
endmodule

// ==== hdl/poly_pkg.sv ====
// Polynomial actor package with sizes, opcodes, command word views, status layout and token port
package poly_pkg;
    localparam int word_w = 16;
    localparam int fifo_depth = 16;
    localparam int cnt_w = $clog2(fifo_depth + 1);
    localparam int slot_count = 8;
    localparam int max_degree = 10;
    localparam int coef_words = slot_count * (max_degree + 1);  // 88 coefficient words
    localparam int addr_w = $clog2(coef_words);

    localparam logic [7:0] op_stp = 8'd0;
    localparam logic [7:0] op_evp = 8'd1;
    localparam logic [7:0] op_evb = 8'd2;
    localparam logic [7:0] op_rst = 8'd3;

    // Firing controller states
    localparam logic [3:0] fc_idle = 4'd0;
    localparam logic [3:0] fc_fetch_start = 4'd1;
    localparam logic [3:0] fc_fetch_wait = 4'd2;
    localparam logic [3:0] fc_decode = 4'd3;
    localparam logic [3:0] fc_stp_start = 4'd4;
    localparam logic [3:0] fc_stp_wait = 4'd5;
    localparam logic [3:0] fc_eval_start = 4'd6;
    localparam logic [3:0] fc_eval_wait = 4'd7;
    localparam logic [3:0] fc_clear = 4'd8;
    localparam logic [3:0] fc_err_out = 4'd9;

    // Evaluation engine states
    localparam logic [1:0] pe_idle = 2'd0;
    localparam logic [1:0] pe_wait_x = 2'd1;
    localparam logic [1:0] pe_run = 2'd2;
    localparam logic [1:0] pe_err = 2'd3;

    typedef struct packed {
        logic [7:0] opcode;
        logic [2:0] slot;
        logic [4:0] degree;
    } stp_view_t;

    typedef struct packed {
        logic [7:0] opcode;
        logic [2:0] slot;
        logic [4:0] count;
    } evb_view_t;

    typedef union packed {
        stp_view_t stp_view;
        evb_view_t evb_view;
    } cmd_word_u;

    function automatic logic [31:0] make_status(input logic [7:0] op, input logic [2:0] slot,
                                                input logic [4:0] degree, input logic err,
                                                input logic [14:0] index);
        return {op, slot, degree, err, index};
    endfunction
endpackage

`timescale 1ns/1ps
// Read side of a token FIFO as seen by its single consumer
interface tok_rd_if import poly_pkg::*; ();
    logic              pop;
    logic [word_w-1:0] token;
    logic [cnt_w-1:0]  count;
    logic              empty;

    modport owner (input pop, output token, output count, output empty);
    modport reader (output pop, input token, input count, input empty);
endinterface

// ==== hdl/token_fifo.sv ====
// Token FIFO that buffers one input stream and shows its head token to one reader
`timescale 1ns/1ps
module token_fifo import poly_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic [word_w-1:0] token_in,
    output logic              full,
    tok_rd_if.owner           rd
);
    logic [word_w-1:0]             mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic [cnt_w-1:0]              count;
    logic                          do_push;
    logic                          do_pop;

    assign do_push = push && !full;             // A push into a full FIFO is dropped
    assign do_pop = rd.pop && !rd.empty;
    assign full = (count == cnt_w'(fifo_depth));
    assign rd.empty = (count == '0);
    assign rd.count = count;
    assign rd.token = mem[rd_ptr];              // Head token is valid whenever empty is low

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;        // Depth is a power of two so pointers wrap
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (!do_push && do_pop)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= token_in;
    end

    // Consumers must check empty before taking the head token
    assert property (@(posedge clk) disable iff (!rst) rd.empty |-> !rd.pop)
        else $error("token_fifo: pop while empty");
endmodule

// ==== testbench/tb_poly_actor.sv ====
// Testbench for the polynomial actor with a token-level reference model and result checks
`timescale 1ns/1ps
module tb_poly_actor import poly_pkg::*; ();
    localparam int timeout_cycles = 4000;       // About ten times the longest command sequence
    localparam int exp_depth = 128;

    logic              clk;
    logic              rst;
    logic              data_push;
    logic [word_w-1:0] data_token;
    logic              cmd_push;
    logic [word_w-1:0] cmd_token;
    logic              data_full;
    logic              cmd_full;
    logic              result_valid;
    logic [31:0]       result;
    logic [31:0]       status;

    integer                   seed;
    int                       errors;
    int                       cycles;
    int                       results_seen;
    int                       exp_wr;
    int                       exp_rd;
    logic [31:0]              exp_result [exp_depth];
    logic [31:0]              exp_status [exp_depth];
    logic signed [word_w-1:0] model_coef [slot_count][max_degree + 1];
    logic [4:0]               model_deg [slot_count];
    logic [slot_count-1:0]    model_valid;
    logic [word_w-1:0]        model_data_q [$];     // Tokens the model has not consumed yet
    logic [word_w-1:0]        drive_q [$];          // Tokens not yet pushed into the DUT

    poly_actor u_dut (.clk(clk), .rst(rst), .data_push(data_push), .data_token(data_token),
                      .cmd_push(cmd_push), .cmd_token(cmd_token), .data_full(data_full),
                      .cmd_full(cmd_full), .result_valid(result_valid), .result(result),
                      .status(status));

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] pack_status(input logic [7:0] op, input logic [2:0] slot,
                                                input logic [4:0] deg, input logic err,
                                                input int idx);
        return {op, slot, deg, err, idx[14:0]};
    endfunction

    function automatic logic [word_w-1:0] random_token();
        logic [31:0] r;
        r = $random(seed);
        return r[word_w-1:0];
    endfunction

    task automatic expect_out(input logic [31:0] res, input logic [31:0] stat);
        exp_result[exp_wr] = res;
        exp_status[exp_wr] = stat;
        exp_wr++;
    endtask

    task automatic plan_token(input logic [word_w-1:0] v);
        model_data_q.push_back(v);
        drive_q.push_back(v);
    endtask

    // Applies one command to the model in the order the actor fires it
    task automatic model_command(input logic [7:0] op, input logic [2:0] slot,
                                 input logic [4:0] arg);
        int                       n;
        int                       acc;
        logic signed [word_w-1:0] x;
        case (op)
            op_stp:
                if (int'(arg) > max_degree)
                    expect_out(32'd0, pack_status(op, slot, arg, 1'b1, 0));
                else
                begin
                    for (int i = 0; i <= int'(arg); i++)
                        model_coef[slot][i] = model_data_q.pop_front();  // Highest order first
                    model_deg[slot] = arg;
                    model_valid[slot] = 1'b1;
                end
            op_evp, op_evb:
            begin
                n = (op == op_evb && arg != 5'd0) ? int'(arg) : 1;
                if (!model_valid[slot])
                    expect_out(32'd0, pack_status(op, slot, model_deg[slot], 1'b1, 0));
                else
                    for (int k = 0; k < n; k++)
                    begin
                        x = model_data_q.pop_front();
                        acc = 0;
                        for (int i = 0; i <= int'(model_deg[slot]); i++)
                            acc = acc * int'(x) + int'(model_coef[slot][i]);
                        expect_out(acc, pack_status(op, slot, model_deg[slot], 1'b0, k));
                    end
            end
            op_rst:
                model_valid = '0;                               // Degrees stay in the table
            default:
                expect_out(32'd0, pack_status(op, slot, arg, 1'b1, 0));
        endcase
    endtask

    task automatic push_cmd(input logic [word_w-1:0] w);
        @(posedge clk);
        cmd_push <= 1'b1;
        cmd_token <= w;
        @(posedge clk);
        cmd_push <= 1'b0;
    endtask

    task automatic issue(input logic [7:0] op, input logic [2:0] slot, input logic [4:0] arg);
        model_command(op, slot, arg);
        push_cmd({op, slot, arg});
    endtask

    task automatic flush_tokens(input int max_gap);
        logic [word_w-1:0] v;
        logic [31:0]       r;
        int                gap;
        while (drive_q.size() > 0)
        begin
            v = drive_q.pop_front();
            gap = 0;
            if (max_gap > 0)
            begin
                r = $random(seed);
                gap = int'(r[7:0]) % (max_gap + 1);
            end
            repeat (gap) @(posedge clk);
            @(negedge clk);
            while (data_full)
                @(negedge clk);
            @(posedge clk);
            data_push <= 1'b1;
            data_token <= v;
            @(posedge clk);
            data_push <= 1'b0;
        end
    endtask

    task automatic load_slot(input logic [2:0] slot, input logic [4:0] degree);
        for (int i = 0; i <= int'(degree); i++)
            plan_token(random_token());
        issue(op_stp, slot, degree);
        flush_tokens(0);
    endtask

    task automatic eval_once(input logic [2:0] slot);
        plan_token(random_token());
        issue(op_evp, slot, 5'd0);
        flush_tokens(0);
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (exp_rd < exp_wr)
            @(negedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic compare_data_full();
        logic exp_full;
        @(negedge clk);
        exp_full = (model_data_q.size() >= fifo_depth);   // Unconsumed tokens all sit in the FIFO
        assert (data_full == exp_full)
        else
        begin
            $display("Error: data_full = %h, expected %h", data_full, exp_full);
            errors++;
        end
    endtask

    task automatic setup_then_eval();
        load_slot(3'd2, 5'd3);
        eval_once(3'd2);
        wait_drained();
    endtask

    task automatic block_eval_order();
        for (int i = 0; i < 5; i++)
            plan_token(random_token());
        issue(op_evb, 3'd2, 5'd5);
        flush_tokens(6);                                // X tokens arrive with random gaps
        plan_token(random_token());
        issue(op_evb, 3'd2, 5'd0);
        flush_tokens(0);
        wait_drained();
    endtask

    task automatic alternate_slots();
        load_slot(3'd0, 5'd10);
        load_slot(3'd7, 5'd1);
        repeat (3)
        begin
            eval_once(3'd0);
            eval_once(3'd7);
        end
        wait_drained();
    endtask

    task automatic reset_then_reload();
        issue(op_rst, 3'd0, 5'd0);
        eval_once(3'd2);
        wait_drained();
        // The x token left by the failed EVP becomes the top coefficient here
        plan_token(random_token());
        plan_token(random_token());
        issue(op_stp, 3'd2, 5'd2);
        flush_tokens(0);
        eval_once(3'd2);
        wait_drained();
    endtask

    task automatic error_commands_skip_data();
        plan_token(random_token());
        flush_tokens(0);                                // Token waits in the FIFO first
        issue(8'h5a, 3'd3, 5'd7);
        issue(op_stp, 3'd4, 5'd12);
        issue(op_evp, 3'd2, 5'd0);
        wait_drained();
    endtask

    task automatic command_fifo_overflow();
        for (int i = 0; i < 18; i++)
            plan_token(random_token());
        issue(op_evp, 3'd2, 5'd0);                      // Controller stalls with no data
        repeat (8) @(posedge clk);
        for (int i = 0; i < 16; i++)
            issue(op_evp, 3'd2, 5'd0);
        @(negedge clk);
        assert (cmd_full == 1'b1)
        else
        begin
            $display("Error: cmd_full = %h, expected %h", cmd_full, 1'b1);
            errors++;
        end
        push_cmd({op_evb, 3'd0, 5'd3});                 // Must be dropped
        @(negedge clk);
        assert (cmd_full == 1'b1)
        else
        begin
            $display("Error: cmd_full = %h, expected %h", cmd_full, 1'b1);
            errors++;
        end
        flush_tokens(0);
        wait_drained();
    endtask

    task automatic data_fifo_fill();
        compare_data_full();
        while (model_data_q.size() < fifo_depth)
            plan_token(random_token());
        flush_tokens(0);                                // No command is waiting to consume them
        compare_data_full();
    endtask

    always @(posedge clk)
    begin
        if (rst && result_valid)
        begin
            results_seen <= results_seen + 1;
            if (exp_rd < exp_wr)
                exp_rd <= exp_rd + 1;
        end
    end

    // Outputs are registered on the rising edge so the falling edge sees them settled
    assert property (@(negedge clk) disable iff (!rst) result_valid |-> (exp_rd < exp_wr))
        else
        begin
            $display("Result output appeared with no result expected");
            errors++;
        end

    assert property (@(negedge clk) disable iff (!rst)
        (result_valid && exp_rd < exp_wr) |-> (result == exp_result[exp_rd]))
        else
        begin
            $display("Error: result = %h, expected %h", result, exp_result[exp_rd]);
            errors++;
        end

    assert property (@(negedge clk) disable iff (!rst)
        (result_valid && exp_rd < exp_wr) |-> (status == exp_status[exp_rd]))
        else
        begin
            $display("Error: status = %h, expected %h", status, exp_status[exp_rd]);
            errors++;
        end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial
    begin
        seed = 32'h8ac9_d48e;
        errors = 0;
        cycles = 0;
        results_seen = 0;
        exp_wr = 0;
        exp_rd = 0;
        model_valid = '0;
        rst = 1'b0;
        data_push = 1'b0;
        data_token = '0;
        cmd_push = 1'b0;
        cmd_token = '0;
        for (int s = 0; s < slot_count; s++)
            model_deg[s] = 5'd0;
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        setup_then_eval();
        block_eval_order();
        alternate_slots();
        reset_then_reload();
        error_commands_skip_data();
        command_fifo_overflow();
        data_fifo_fill();
        repeat (40) @(posedge clk);                     // Room for any extra output to show up
        if (results_seen != exp_wr)
        begin
            $display("Result count %0d does not match the %0d expected results",
                     results_seen, exp_wr);
            errors++;
        end
        $display("Summary: %0d results checked, %0d errors", results_seen, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end
endmodule
